/* cw_consts.svh */
`ifndef CW_CONSTS_SVH
`define CW_CONSTS_SVH

// register bus geometry
`define CW_ADDR_W           6                         // reg_address width
`define CW_BYTECNT_W        7                         // reg_bytecnt width

// register map
`define CW_TRIGSRC_ADDR     6'd39                     // trigger source and combine
`define CW_TRIGMOD_ADDR     6'd40                     // trigger module select
`define CW_IOROUTE_ADDR     6'd55                     // 8-byte target io routing
`define CW_IOREAD_ADDR      6'd59                     // 4-bit pin sample, read only

// reset values
`define CW_TRIGSRC_RST      8'h20                     // pin 4 enabled, OR combine
`define CW_IOROUTE_RST      64'h0000_0000_0000_0201   // pin 1 tx, pin 2 rx

// io routing layout
`define CW_IOROUTE_BYTES    8                         // bytes in routing register
`define CW_GLITCH_BYTE      4                         // glitch byte, unused here

// soft-start defaults
`define CW_PWM_BITS         11                        // free-running pwm width
`define CW_PWM_ON           1400                      // off-duty threshold
`define CW_SOFT_STEPS_BITS  14                        // log2 of soft-start periods

`endif

/* cw_io_router.sv */
`default_nettype none

module cw_io_router (
   input  wire                                                        clk_usb,
   input  wire                                                        reset,
   input  wire cw_reg_pkg::gpio_route_t [cw_route_pkg::CW_NUM_PINS-1:0] route_i,
   input  wire                                                        highz_i,
   input  wire                                                        uart_tx_i,
   input  wire                                                        usi_out_i,
   input  wire cw_route_pkg::pin_vec_t                                pin_i,
   output cw_route_pkg::pin_vec_t                                     pin_o,
   output cw_route_pkg::pin_vec_t                                     pin_oe_o,
   output logic                                                       uart_rx_o,
   output logic                                                       usi_in_o,
   output cw_route_pkg::pin_vec_t                                     ioread_o
);
   import cw_reg_pkg::*;
   import cw_route_pkg::*;

   localparam pin_vec_t USI_PINS    = 4'b0101;  // usi drive on pins 1 and 3
   localparam pin_vec_t OC_PINS     = 4'b0100;  // open collector on pin 3
   localparam pin_vec_t USI_IN_PINS = 4'b0111;  // usi receive from pins 1..3

   // pin drive, first matching mode wins
   always_comb begin : drive
      gpio_route_t r;
      pin_o    = '0;
      pin_oe_o = '0;
      for (int i = 0; i < CW_NUM_PINS; i++) begin
         r = route_i[i];
         if (r.tx) begin
            pin_o[i]    = uart_tx_i;
            pin_oe_o[i] = 1'b1;
         end else if (r.usi_o && USI_PINS[i]) begin
            pin_o[i]    = usi_out_i;
            pin_oe_o[i] = 1'b1;
         end else if (r.usi_oc && OC_PINS[i]) begin
            pin_oe_o[i] = ~usi_out_i;  // pull low on 0, float on 1
         end else if (r.tx_oc && OC_PINS[i]) begin
            pin_oe_o[i] = ~uart_tx_i;  // same for tx
         end else if (r.gpio_en) begin
            pin_o[i]    = r.gpio_val;  // static level
            pin_oe_o[i] = 1'b1;
         end
      end
      if (highz_i) begin
         pin_oe_o = '0;                // target unpowered, release all
      end
   end

   // receive select, lowest pin wins
   always_comb begin : rx_sel
      uart_rx_o = 1'b1;                // idle uart level
      usi_in_o  = 1'b1;
      for (int i = CW_NUM_PINS - 1; i >= 0; i--) begin
         if (route_i[i].rx) begin
            uart_rx_o = pin_i[i];
         end
         if (route_i[i].usi_i && USI_IN_PINS[i]) begin
            usi_in_o = pin_i[i];
         end
      end
   end

   // pin sample for the ioread register
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ioread_o <= '0;
      end else begin
         ioread_o <= pin_i;
      end
   end

endmodule

`default_nettype wire

/* cw_io_top.sv */
`default_nettype none
`include "cw_consts.svh"

module cw_io_top #(
   parameter int P_PWM_BITS   = `CW_PWM_BITS,
   parameter int P_PWM_ON     = `CW_PWM_ON,
   parameter int P_STEPS_BITS = `CW_SOFT_STEPS_BITS
) (
   input  wire                         clk_usb,
   input  wire                         reset,
   input  wire [`CW_ADDR_W-1:0]        reg_address_i,
   input  wire [`CW_BYTECNT_W-1:0]     reg_bytecnt_i,
   input  wire [7:0]                   reg_datai_i,
   input  wire                         reg_read_i,
   input  wire                         reg_write_i,
   input  wire                         reg_addrvalid_i,
   output logic [7:0]                  reg_datao_o,
   input  wire cw_route_pkg::pin_vec_t trig_io_i,
   input  wire                         trigger_advio_i,
   input  wire                         trigger_anapattern_i,
   input  wire                         trigger_decodedio_i,
   output logic                        trigger_ext_o,
   output logic                        trigger_o,
   input  wire                         uart_tx_i,
   output logic                        uart_rx_o,
   input  wire                         usi_out_i,
   output logic                        usi_in_o,
   output cw_route_pkg::pin_vec_t      pin_o,
   output cw_route_pkg::pin_vec_t      pin_oe_o,
   input  wire cw_route_pkg::pin_vec_t pin_i,
   output logic                        targetpower_off_o,
   output logic                        enable_avrprog_o,
   output logic                        enable_output_nrst_o,
   output logic                        output_nrst_o,
   output logic                        enable_output_pdid_o,
   output logic                        output_pdid_o,
   output logic                        enable_output_pdic_o,
   output logic                        output_pdic_o
);
   import cw_reg_pkg::*;
   import cw_route_pkg::*;

   trigsrc_t          trigsrc;
   trigmod_t          trigmod;
   gpio_route_t [3:0] route;
   extra_t            extra;
   extra_gpio_t       extra_gpio;
   pin_vec_t          ioread;
   logic              highz;     // power off, pins released

   cw_reg_file u_reg_file (
      .clk_usb, .reset,
      .reg_address_i, .reg_bytecnt_i, .reg_datai_i,
      .reg_read_i, .reg_write_i, .reg_addrvalid_i,
      .ioread_i     (ioread),
      .reg_datao_o,
      .trigsrc_o    (trigsrc),
      .trigmod_o    (trigmod),
      .route_o      (route),
      .extra_o      (extra),
      .extra_gpio_o (extra_gpio)
   );

   cw_trigger_sel u_trigger_sel (
      .trigsrc_i (trigsrc),
      .trigmod_i (trigmod),
      .trig_io_i, .trigger_advio_i, .trigger_anapattern_i, .trigger_decodedio_i,
      .trigger_ext_o, .trigger_o
   );

   cw_io_router u_io_router (
      .clk_usb, .reset,
      .route_i  (route),
      .highz_i  (highz),
      .uart_tx_i, .usi_out_i, .pin_i,
      .pin_o, .pin_oe_o, .uart_rx_o, .usi_in_o,
      .ioread_o (ioread)
   );

   cw_target_power #(
      .P_PWM_BITS   (P_PWM_BITS),
      .P_PWM_ON     (P_PWM_ON),
      .P_STEPS_BITS (P_STEPS_BITS)
   ) u_target_power (
      .clk_usb, .reset,
      .power_off_i  (extra.power_off),
      .power_fast_i (extra.power_fast),
      .targetpower_off_o,
      .highz_o      (highz)
   );

   assign enable_avrprog_o     = extra.avrprog;
   assign enable_output_nrst_o = extra_gpio.nrst_en;   // nrst as gpio
   assign output_nrst_o        = extra_gpio.nrst;
   assign enable_output_pdid_o = extra_gpio.pdid_en;
   assign output_pdid_o        = extra_gpio.pdid;
   assign enable_output_pdic_o = extra_gpio.pdic_en;
   assign output_pdic_o        = extra_gpio.pdic;

endmodule

`default_nettype wire

/* cw_reg_file.sv */
`default_nettype none
`include "cw_consts.svh"

module cw_reg_file (
   input  wire                           clk_usb,
   input  wire                           reset,
   input  wire [`CW_ADDR_W-1:0]          reg_address_i,
   input  wire [`CW_BYTECNT_W-1:0]       reg_bytecnt_i,
   input  wire [7:0]                     reg_datai_i,
   input  wire                           reg_read_i,
   input  wire                           reg_write_i,
   input  wire                           reg_addrvalid_i,
   input  wire cw_route_pkg::pin_vec_t   ioread_i,      // registered pin sample
   output logic [7:0]                    reg_datao_o,
   output cw_reg_pkg::trigsrc_t          trigsrc_o,
   output cw_reg_pkg::trigmod_t          trigmod_o,
   output cw_reg_pkg::gpio_route_t [3:0] route_o,       // pins 4..1
   output cw_reg_pkg::extra_t            extra_o,
   output cw_reg_pkg::extra_gpio_t       extra_gpio_o
);
   import cw_reg_pkg::*;

   localparam int IDX_W      = $clog2(`CW_IOROUTE_BYTES);
   localparam int EXTRA_BYTE = 5;  // avrprog / power byte
   localparam int XGPIO_BYTE = 6;  // nrst / pdid / pdic byte

   trigsrc_t          trigsrc_q;
   trigmod_t          trigmod_q;
   ioroute_t          ioroute_q;
   logic [IDX_W-1:0]  byte_idx;
   logic              byte_ok;
   logic              rsvd_byte;
   logic [7:0]        rd_data;
   logic [7:0]        rd_data_q;
   logic              rd_valid_q;

   assign byte_idx  = reg_bytecnt_i[IDX_W-1:0];
   assign byte_ok   = (reg_bytecnt_i < `CW_IOROUTE_BYTES);         // counts of 8+ hit nothing
   assign rsvd_byte = (byte_idx == IDX_W'(`CW_GLITCH_BYTE));       // old glitch byte

   // register writes, land at the write edge
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trigsrc_q <= `CW_TRIGSRC_RST;
         trigmod_q <= '0;
         ioroute_q <= `CW_IOROUTE_RST;
      end else if (reg_write_i && byte_ok) begin
         case (reg_address_i)
            `CW_TRIGSRC_ADDR: trigsrc_q <= reg_datai_i;
            `CW_TRIGMOD_ADDR: trigmod_q <= reg_datai_i;
            `CW_IOROUTE_ADDR: begin
               if (!rsvd_byte) begin
                  ioroute_q[byte_idx] <= reg_datai_i;  // byte 4 stays 0
               end
            end
            default: ;                                 // unmapped, dropped
         endcase
      end
   end

   // read mux, unmapped and out of range give 0
   always_comb begin
      rd_data = '0;
      if (byte_ok) begin
         case (reg_address_i)
            `CW_TRIGSRC_ADDR: rd_data = trigsrc_q;
            `CW_TRIGMOD_ADDR: rd_data = trigmod_q;
            `CW_IOROUTE_ADDR: begin
               if (!rsvd_byte) begin
                  rd_data = ioroute_q[byte_idx];
               end
            end
            `CW_IOREAD_ADDR:  rd_data = {4'b0000, ioread_i};
            default:          rd_data = '0;
         endcase
      end
   end

   // one cycle read latency
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= reg_read_i & reg_addrvalid_i;  // high only the cycle after a read
      end
   end

   always_ff @(posedge clk_usb) begin
      if (reg_read_i && reg_addrvalid_i) begin
         rd_data_q <= rd_data;  // payload, no reset
      end
   end

   assign reg_datao_o = rd_valid_q ? rd_data_q : 8'h00;  // bus idles at 0

   assign trigsrc_o    = trigsrc_q;
   assign trigmod_o    = trigmod_q;
   assign route_o      = ioroute_q[3:0];           // pin bytes 0..3
   assign extra_o      = ioroute_q[EXTRA_BYTE];
   assign extra_gpio_o = ioroute_q[XGPIO_BYTE];

endmodule

`default_nettype wire

/* cw_reg_pkg.sv */
`default_nettype none
`include "cw_consts.svh"

package cw_reg_pkg;

   // trigger source byte at 39
   typedef struct packed {
      logic [1:0] mode;      // combine mode, see combine_e
      logic [3:0] mask;      // target io 4..1 enables
      logic       fb;        // front panel b
      logic       fa;        // front panel a / aux sma
   } trigsrc_t;

   // trigger module byte at 40
   typedef struct packed {
      logic [4:0] rsvd;
      logic [2:0] src;       // see trig_src_e
   } trigmod_t;

   // one routing byte per target pin
   typedef struct packed {
      logic gpio_en;         // static drive enable
      logic gpio_val;        // static drive level
      logic tx_oc;           // tx open collector, pin 3 only
      logic usi_oc;          // usi open collector, pin 3 only
      logic usi_i;           // pin feeds usi_in
      logic usi_o;           // pin driven by usi_out
      logic rx;              // pin feeds uart_rx
      logic tx;              // pin driven by uart_tx
   } gpio_route_t;

   // routing byte 5
   typedef struct packed {
      logic [4:0] rsvd;
      logic       power_fast;  // skip soft-start
      logic       power_off;   // target power disable
      logic       avrprog;     // avr programming enable
   } extra_t;

   // routing byte 6, enable and state per control line
   typedef struct packed {
      logic [1:0] rsvd;
      logic       pdic;
      logic       pdic_en;
      logic       pdid;
      logic       pdid_en;
      logic       nrst;
      logic       nrst_en;
   } extra_gpio_t;

   typedef logic [`CW_IOROUTE_BYTES-1:0][7:0] ioroute_t;  // byte 0 is pin 1

endpackage

`default_nettype wire

/* cw_route_pkg.sv */
`default_nettype none

package cw_route_pkg;

   localparam int CW_NUM_PINS = 4;  // target io lines

   // how masked trigger lines combine
   typedef enum logic [1:0] {
      COMB_OR   = 2'b00,
      COMB_AND  = 2'b01,
      COMB_NAND = 2'b10,
      COMB_OFF  = 2'b11   // forces trigger_ext low
   } combine_e;

   // trigger module select, 4..7 give no trigger
   typedef enum logic [2:0] {
      SRC_EXT        = 3'd0,  // combined io trigger
      SRC_ADVIO      = 3'd1,
      SRC_ANAPATTERN = 3'd2,
      SRC_DECODEDIO  = 3'd3
   } trig_src_e;

   typedef logic [CW_NUM_PINS-1:0] pin_vec_t;  // bit 0 is pin 1

endpackage

`default_nettype wire

/* cw_target_power.sv */
`default_nettype none
`include "cw_consts.svh"

module cw_target_power #(
   parameter int P_PWM_BITS   = `CW_PWM_BITS,
   parameter int P_PWM_ON     = `CW_PWM_ON,          // cycles off per pwm period
   parameter int P_STEPS_BITS = `CW_SOFT_STEPS_BITS  // 2^n soft-start periods
) (
   input  wire  clk_usb,
   input  wire  reset,
   input  wire  power_off_i,     // register bit
   input  wire  power_fast_i,    // skip soft-start
   output logic targetpower_off_o,
   output logic highz_o
);
   localparam logic [P_PWM_BITS-1:0] PWM_ON = P_PWM_BITS'(P_PWM_ON);

   logic                    off_q;
   logic                    off_prev_q;
   logic                    soft_pend_q;   // waiting for first pwm wrap
   logic                    soft_act_q;    // pwm drives the switch
   logic [P_PWM_BITS-1:0]   pwm_q;
   logic [P_STEPS_BITS-1:0] step_q;
   logic                    start_edge;
   logic                    pwm_wrap;

   assign start_edge = ~off_q & off_prev_q & ~power_fast_i;  // power-on edge in slow mode
   assign pwm_wrap   = &pwm_q;                               // last cycle of period

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         off_q      <= 1'b0;
         off_prev_q <= 1'b0;
         pwm_q      <= '0;
      end else begin
         off_q      <= power_off_i;
         off_prev_q <= off_q;
         pwm_q      <= pwm_q + 1'b1;                        // free running
      end
   end

   // soft-start sequencing with one step per pwm period
   always_ff @(posedge clk_usb) begin
      if (reset || off_q) begin
         soft_pend_q <= 1'b0;
         soft_act_q  <= 1'b0;
         step_q      <= '0;
      end else if (start_edge) begin
         soft_pend_q <= 1'b1;
      end else if (pwm_wrap) begin
         if (soft_pend_q) begin
            soft_pend_q <= 1'b0;
            soft_act_q  <= 1'b1;                            // first period starts
            step_q      <= '0;
         end else if (soft_act_q) begin
            if (&step_q) begin
               soft_act_q <= 1'b0;                          // last period so supply stays on
            end else begin
               step_q <= step_q + 1'b1;
            end
         end
      end
   end

   assign targetpower_off_o = off_q | (soft_act_q & (pwm_q < PWM_ON));
   assign highz_o           = off_q;                        // pins released while off

endmodule

`default_nettype wire

/* cw_trigger_sel.sv */
`default_nettype none

module cw_trigger_sel (
   input  wire cw_reg_pkg::trigsrc_t   trigsrc_i,
   input  wire cw_reg_pkg::trigmod_t   trigmod_i,
   input  wire cw_route_pkg::pin_vec_t trig_io_i,           // target io 4..1
   input  wire                         trigger_advio_i,
   input  wire                         trigger_anapattern_i,
   input  wire                         trigger_decodedio_i,
   output logic                        trigger_ext_o,
   output logic                        trigger_o
);
   import cw_route_pkg::*;

   pin_vec_t masked;
   logic     trig_or;
   logic     trig_and;

   assign masked   = trig_io_i & trigsrc_i.mask;
   assign trig_or  = |masked;                         // disabled lines count as 0
   assign trig_and = &(masked | ~trigsrc_i.mask);     // disabled lines count as 1

   // combine masked io lines
   always_comb begin
      case (combine_e'(trigsrc_i.mode))
         COMB_OR:   trigger_ext_o = trig_or;
         COMB_AND:  trigger_ext_o = trig_and;
         COMB_NAND: trigger_ext_o = ~trig_and;
         default:   trigger_ext_o = 1'b0;             // mode off
      endcase
   end

   // pick the trigger module
   always_comb begin
      case (trig_src_e'(trigmod_i.src))
         SRC_EXT:        trigger_o = trigger_ext_o;
         SRC_ADVIO:      trigger_o = trigger_advio_i;
         SRC_ANAPATTERN: trigger_o = trigger_anapattern_i;
         SRC_DECODEDIO:  trigger_o = trigger_decodedio_i;
         default:        trigger_o = 1'b0;            // 4..7 never fire
      endcase
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
cw_reg_pkg.sv
cw_route_pkg.sv
cw_reg_file.sv
cw_trigger_sel.sv
cw_io_router.sv
cw_target_power.sv
cw_io_top.sv
tb_cw_io.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cw_io -f files.f -o tb_cw_io
./obj_dir/tb_cw_io > sim.log 2>&1
cat sim.log

if grep -q "^Regression passed$" sim.log; then
   exit 0
fi
exit 1

/* tb_cw_io.sv */
`default_nettype none
`include "cw_consts.svh"

module tb_cw_io;
   localparam int N_RW        = 120;
   localparam int N_TRIG      = 150;
   localparam int N_ROUTE     = 120;
   localparam int TEST_CYCLES = 60 + N_RW * 5 + N_TRIG * 6 + N_ROUTE * 12 + 300;

   logic       clk_usb = 1'b0;
   logic       reset = 1'b1;
   logic [5:0] reg_address_i = '0;
   logic [6:0] reg_bytecnt_i = '0;
   logic [7:0] reg_datai_i = '0;
   logic       reg_read_i = 1'b0;
   logic       reg_write_i = 1'b0;
   logic       reg_addrvalid_i = 1'b0;
   logic [3:0] trig_io_i = '0;
   logic       trigger_advio_i = 1'b0;
   logic       trigger_anapattern_i = 1'b0;
   logic       trigger_decodedio_i = 1'b0;
   logic       uart_tx_i = 1'b1;
   logic       usi_out_i = 1'b1;
   logic [3:0] pin_i = '0;
   logic [7:0] reg_datao_o;
   logic       trigger_ext_o;
   logic       trigger_o;
   logic       uart_rx_o;
   logic       usi_in_o;
   logic [3:0] pin_o;
   logic [3:0] pin_oe_o;
   logic       targetpower_off_o;
   logic       enable_avrprog_o;
   logic       enable_output_nrst_o;
   logic       output_nrst_o;
   logic       enable_output_pdid_o;
   logic       output_pdid_o;
   logic       enable_output_pdic_o;
   logic       output_pdic_o;

   logic [7:0] trig_m;            // model of trigger source reg
   logic [7:0] mod_m;
   logic [7:0] rt_m [8];          // routing bytes indexed from pin 1
   logic [3:0] io_m;              // sampled pins
   logic       off_m;             // registered power-off bit
   logic [7:0] rd_m;              // expected bus read data
   int         errors = 0;
   int         checks = 0;
   bit         soft_on = 1'b0;    // pwm phase checked by the power test

   cw_io_top #(.P_PWM_BITS(4), .P_PWM_ON(5), .P_STEPS_BITS(3)) DUT (.*);

   initial forever #4 clk_usb = ~clk_usb;

   function automatic logic [7:0] read_value(input logic [5:0] a, input logic [6:0] c);
      if (c >= 8) return 8'h00;   // past the last byte
      case (a)
         `CW_TRIGSRC_ADDR: return trig_m;
         `CW_TRIGMOD_ADDR: return mod_m;
         `CW_IOROUTE_ADDR: return (c == 4) ? 8'h00 : rt_m[c[2:0]];
         `CW_IOREAD_ADDR:  return {4'h0, io_m};
         default:          return 8'h00;
      endcase
   endfunction

   function automatic logic [1:0] trig_value();   // {trigger_ext, trigger}
      logic [3:0] mask;
      logic       all_on;
      logic       ext;
      mask   = trig_m[5:2];
      all_on = &(trig_io_i | ~mask);              // masked-off lines read as 1
      case (trig_m[7:6])
         2'd0:    ext = |(trig_io_i & mask);
         2'd1:    ext = all_on;
         2'd2:    ext = ~all_on;
         default: ext = 1'b0;
      endcase
      case (mod_m[2:0])
         3'd0:    return {ext, ext};
         3'd1:    return {ext, trigger_advio_i};
         3'd2:    return {ext, trigger_anapattern_i};
         3'd3:    return {ext, trigger_decodedio_i};
         default: return {ext, 1'b0};
      endcase
   endfunction

   function automatic logic [7:0] drive_value();  // {oe, driven level}
      logic [3:0] o;
      logic [3:0] oe;
      o  = '0;
      oe = '0;
      for (int i = 0; i < 4; i++) begin
         if (rt_m[i][0]) {oe[i], o[i]} = {1'b1, uart_tx_i};
         else if (rt_m[i][2] && i != 1 && i != 3) {oe[i], o[i]} = {1'b1, usi_out_i};
         else if (rt_m[i][4] && i == 2) {oe[i], o[i]} = {~usi_out_i, 1'b0};
         else if (rt_m[i][5] && i == 2) {oe[i], o[i]} = {~uart_tx_i, 1'b0};
         else if (rt_m[i][7]) {oe[i], o[i]} = {1'b1, rt_m[i][6]};
      end
      if (off_m) oe = '0;                         // supply off releases every pin
      return {oe, o & oe};
   endfunction

   function automatic logic [1:0] recv_value();   // {uart_rx, usi_in}
      logic rx;
      logic usi;
      rx  = 1'b1;
      usi = 1'b1;
      for (int i = 3; i >= 0; i--) begin          // lower pins overwrite
         if (rt_m[i][1]) rx = pin_i[i];
         if (rt_m[i][3] && i != 3) usi = pin_i[i];
      end
      return {rx, usi};
   endfunction

   task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Fail %s expected %h got %h at %0t", name, exp, got, $time);
      end
   endtask

   // reference model clocked on the DUT edges
   always @(posedge clk_usb) begin
      if (reset) begin
         trig_m <= `CW_TRIGSRC_RST;
         mod_m  <= 8'h00;
         for (int i = 0; i < 8; i++) rt_m[i] <= 8'(`CW_IOROUTE_RST >> (8 * i));
         io_m   <= '0;
         off_m  <= 1'b0;
         rd_m   <= 8'h00;
      end else begin
         if (reg_write_i && reg_bytecnt_i < 8) begin
            if (reg_address_i == `CW_TRIGSRC_ADDR) trig_m <= reg_datai_i;
            if (reg_address_i == `CW_TRIGMOD_ADDR) mod_m <= reg_datai_i;
            if (reg_address_i == `CW_IOROUTE_ADDR && reg_bytecnt_i != 4)
               rt_m[reg_bytecnt_i[2:0]] <= reg_datai_i;
         end
         if (reg_read_i && reg_addrvalid_i)
            rd_m <= read_value(reg_address_i, reg_bytecnt_i);
         else
            rd_m <= 8'h00;
         io_m  <= pin_i;
         off_m <= rt_m[5][1];
      end
   end

   // outputs settled mid-cycle
   always @(negedge clk_usb) begin
      if (!reset) begin
         check_value("reg_datao_o", rd_m, reg_datao_o);
         check_value("trigger_ext_o/trigger_o", 8'(trig_value()), {trigger_ext_o, trigger_o});
         check_value("pin_oe_o/pin_o", drive_value(), {pin_oe_o, pin_o & pin_oe_o});
         check_value("uart_rx_o/usi_in_o", 8'(recv_value()), {uart_rx_o, usi_in_o});
         check_value("gpio outputs", {rt_m[6][5:0], rt_m[5][0]},
                     {output_pdic_o, enable_output_pdic_o, output_pdid_o, enable_output_pdid_o,
                      output_nrst_o, enable_output_nrst_o, enable_avrprog_o});
         if (!soft_on) check_value("targetpower_off_o", 8'(off_m), targetpower_off_o);
      end
   end

   task automatic write_reg(input logic [5:0] a, input logic [6:0] c, input logic [7:0] d);
      @(posedge clk_usb);
      #1;
      reg_address_i = a;
      reg_bytecnt_i = c;
      reg_datai_i   = d;
      reg_write_i   = 1'b1;
      @(posedge clk_usb);
      #1;
      reg_write_i = 1'b0;
   endtask

   task automatic read_expect(input logic [5:0] a, input logic [6:0] c, input logic [7:0] exp);
      @(posedge clk_usb);
      #1;
      reg_address_i   = a;
      reg_bytecnt_i   = c;
      reg_read_i      = 1'b1;
      reg_addrvalid_i = 1'b1;
      @(posedge clk_usb);
      #1;
      reg_read_i      = 1'b0;
      reg_addrvalid_i = 1'b0;
      @(negedge clk_usb);                        // data cycle
      check_value("reg_datao_o", exp, reg_datao_o);
   endtask

   initial begin
      #(TEST_CYCLES * 12);                       // 1.5 x test cycles x 8 units
      $display("watchdog timeout, the tests did not finish in time");
      $display("Regression failed");
      $finish;
   end

   initial begin
      logic [5:0] a;
      logic [6:0] c;
      logic [7:0] d;
      logic [7:0] e;
      int         hits;
      void'($urandom(32'hf8c9));
      repeat (2) @(posedge clk_usb);
      #1;
      reset = 1'b0;

      read_expect(`CW_TRIGSRC_ADDR, 0, 8'h20);
      read_expect(`CW_TRIGMOD_ADDR, 0, 8'h00);
      for (int b = 0; b < 8; b++) begin
         read_expect(`CW_IOROUTE_ADDR, 7'(b), (b < 2) ? 8'(b + 1) : 8'h00);
      end
      read_expect(`CW_IOREAD_ADDR, 0, 8'h00);
      check_value("pin_oe_o", 8'h01, pin_oe_o);   // only pin 1 drives
      check_value("enables/targetpower_off_o", 8'h00, {enable_avrprog_o, enable_output_nrst_o,
                  enable_output_pdid_o, enable_output_pdic_o, targetpower_off_o});
      $display("test 1 reset values done, errors %0d", errors);

      for (int n = 0; n < N_RW; n++) begin
         case ($urandom_range(5))
            0:       a = `CW_TRIGSRC_ADDR;
            1:       a = `CW_TRIGMOD_ADDR;
            2, 3:    a = `CW_IOROUTE_ADDR;
            4:       a = `CW_IOREAD_ADDR;
            default: a = 6'($urandom_range(38));  // below the map
         endcase
         c = 7'($urandom_range(9));
         d = 8'($urandom);
         if (a == `CW_IOROUTE_ADDR && c == 5) d[2] = 1'b1;  // keep fast power so no soft-start runs
         if (c >= 8 || a < 39 || a == `CW_IOREAD_ADDR || (a == `CW_IOROUTE_ADDR && c == 4))
            e = 8'h00;
         else
            e = d;
         write_reg(a, c, d);
         read_expect(a, c, e);
      end
      $display("test 2 register write and read done, errors %0d", errors);

      for (int n = 0; n < N_TRIG; n++) begin
         write_reg(`CW_TRIGSRC_ADDR, 0, 8'($urandom));
         write_reg(`CW_TRIGMOD_ADDR, 0, 8'($urandom));
         repeat (2) begin
            @(posedge clk_usb);
            #1;
            {trig_io_i, trigger_advio_i, trigger_anapattern_i, trigger_decodedio_i} = 7'($urandom);
         end
      end
      $display("test 3 trigger select done, errors %0d", errors);

      write_reg(`CW_IOROUTE_ADDR, 5, 8'h04);     // supply on
      for (int n = 0; n < N_ROUTE; n++) begin
         for (int b = 0; b < 4; b++) write_reg(`CW_IOROUTE_ADDR, 7'(b), 8'($urandom));
         @(posedge clk_usb);
         #1;
         {pin_i, uart_tx_i, usi_out_i} = 6'($urandom);
         read_expect(`CW_IOREAD_ADDR, 0, {4'h0, pin_i});
      end
      $display("test 4 io routing done, errors %0d", errors);

      write_reg(`CW_IOROUTE_ADDR, 5, 8'h02);
      @(posedge clk_usb);
      @(negedge clk_usb);
      check_value("targetpower_off_o", 8'h01, targetpower_off_o);
      check_value("pin_oe_o", 8'h00, pin_oe_o);
      write_reg(`CW_IOROUTE_ADDR, 5, 8'h06);
      write_reg(`CW_IOROUTE_ADDR, 5, 8'h04);     // fast power on
      @(posedge clk_usb);
      @(negedge clk_usb);
      check_value("targetpower_off_o", 8'h00, targetpower_off_o);
      repeat (20) @(posedge clk_usb);            // longer than one pwm period plus the wait
      write_reg(`CW_IOROUTE_ADDR, 5, 8'h02);
      soft_on = 1'b1;
      write_reg(`CW_IOROUTE_ADDR, 5, 8'h00);     // slow power on
      @(posedge clk_usb);
      hits = 0;
      do begin
         @(negedge clk_usb);
         hits++;
      end while (!targetpower_off_o && hits < 64);
      if (!targetpower_off_o) begin
         errors++;
         $display("soft-start never began switching the target supply");
      end else begin
         for (int p = 0; p < 8; p++) begin       // windows start on the first high
            hits = 0;
            repeat (16) begin
               hits += targetpower_off_o;
               @(negedge clk_usb);
            end
            check_value("targetpower_off_o high cycles", 8'd5, 8'(hits));
         end
         repeat (32) begin
            check_value("targetpower_off_o", 8'h00, targetpower_off_o);
            @(negedge clk_usb);
         end
      end
      soft_on = 1'b0;
      $display("test 5 target power done, errors %0d", errors);

      $display("5 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire
